//--- bt_rx_top.f
+incdir+hw
hw/bt_pkg.sv
hw/bt_timebase.sv
hw/bt_rx_sampler.sv
hw/bt_sync_correlator.sv
hw/bt_sync_reporter.sv
hw/bt_rx_top.sv
tb/bt_rx_checker.sv
tb/tb_bt_rx.sv

//--- hw/bt_params.svh
`ifndef BT_PARAMS_SVH
`define BT_PARAMS_SVH

////////////////////////////////
// widths
////////////////////////////////

// access code length in bits
`define BT_SYNC_W 64
// native clock CLKN
`define BT_CLKN_W 28
// holds a match count of 0..64
`define BT_CORR_W 7
`define BT_DROP_W 8

////////////////////////////////
// timing counts in clk_6M cycles
////////////////////////////////

`define BT_US_DIV 6
// 312.5 us half slot
`define BT_HSLOT_DIV 1875

`endif

//--- hw/bt_pkg.sv
package bt_pkg;

  ////////////////////////////////
  // access mode
  ////////////////////////////////

  // picks the expected access code and is reported with every event
  typedef enum logic [1:0]
  {
    ACC_CAC  = 2'd0,
    ACC_DAC  = 2'd1,
    ACC_GIAC = 2'd2
  } access_mode_t;

  ////////////////////////////////
  // correlator FSM
  ////////////////////////////////

  // holdoff blocks repeat hits while the code slides out of the window
  typedef enum logic
  {
    CORR_ARMED   = 1'b0,
    CORR_HOLDOFF = 1'b1
  } corr_state_t;

endpackage

//--- hw/bt_rx_sampler.sv
`timescale 1ns/100ps
`include "bt_params.svh"

module bt_rx_sampler
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  rxbit,
  input  logic                  us_tick,
  output logic [`BT_SYNC_W-1:0] sync_window,
  output logic                  bit_strobe
);

  logic rx_meta;
  logic rx_sync;

  ////////////////////////////////
  // resync of the async rx input
  ////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      rx_meta <= 1'b0;
      rx_sync <= 1'b0;
    end
    else
    begin
      rx_meta <= rxbit;
      rx_sync <= rx_meta;
    end
  end

  ////////////////////////////////
  // 1 us sampling into the window
  ////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      sync_window <= '0;
      bit_strobe  <= 1'b0;
    end
    else
    begin
      // newest bit at the lsb
      if (us_tick)
        sync_window <= {sync_window[`BT_SYNC_W-2:0], rx_sync};
      // marks the cycle the shifted window is visible
      bit_strobe <= us_tick;
    end
  end

endmodule

//--- hw/bt_rx_top.sv
`timescale 1ns/100ps
`include "bt_params.svh"

module bt_rx_top import bt_pkg::*;
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  rxbit,
  input  access_mode_t          access_mode,
  input  logic [`BT_SYNC_W-1:0] syncword_cac,
  input  logic [`BT_SYNC_W-1:0] syncword_dac,
  input  logic [`BT_SYNC_W-1:0] syncword_giac,
  input  logic [`BT_CORR_W-1:0] correthreshold,
  input  logic                  evt_ready,
  output logic [`BT_CLKN_W-1:0] clkn,
  output logic                  slot_p,
  output logic                  evt_valid,
  output logic [`BT_CLKN_W-1:0] evt_clkn,
  output access_mode_t          evt_mode,
  output logic [`BT_DROP_W-1:0] drop_count
);

  logic                  us_tick;
  logic [`BT_SYNC_W-1:0] sync_window;
  logic                  bit_strobe;
  logic                  hit_p;
  access_mode_t          hit_mode;

  ////////////////////////////////
  // native clock
  ////////////////////////////////

  bt_timebase u_timebase
  (
    .clk_6M (clk_6M ),
    .rstz   (rstz   ),
    .us_tick(us_tick),
    .clkn   (clkn   ),
    .slot_p (slot_p )
  );

  ////////////////////////////////
  // receive path
  ////////////////////////////////

  bt_rx_sampler u_rx_sampler
  (
    .clk_6M     (clk_6M     ),
    .rstz       (rstz       ),
    .rxbit      (rxbit      ),
    .us_tick    (us_tick    ),
    .sync_window(sync_window),
    .bit_strobe (bit_strobe )
  );

  bt_sync_correlator u_sync_correlator
  (
    .clk_6M        (clk_6M        ),
    .rstz          (rstz          ),
    .sync_window   (sync_window   ),
    .bit_strobe    (bit_strobe    ),
    .access_mode   (access_mode   ),
    .syncword_cac  (syncword_cac  ),
    .syncword_dac  (syncword_dac  ),
    .syncword_giac (syncword_giac ),
    .correthreshold(correthreshold),
    .hit_p         (hit_p         ),
    .hit_mode      (hit_mode      )
  );

  // hit events out over valid/ready
  bt_sync_reporter u_sync_reporter
  (
    .clk_6M    (clk_6M    ),
    .rstz      (rstz      ),
    .hit_p     (hit_p     ),
    .hit_mode  (hit_mode  ),
    .clkn      (clkn      ),
    .evt_ready (evt_ready ),
    .evt_valid (evt_valid ),
    .evt_clkn  (evt_clkn  ),
    .evt_mode  (evt_mode  ),
    .drop_count(drop_count)
  );

endmodule

//--- hw/bt_sync_correlator.sv
`timescale 1ns/100ps
`include "bt_params.svh"

module bt_sync_correlator import bt_pkg::*;
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic [`BT_SYNC_W-1:0] sync_window,
  input  logic                  bit_strobe,
  input  access_mode_t          access_mode,
  input  logic [`BT_SYNC_W-1:0] syncword_cac,
  input  logic [`BT_SYNC_W-1:0] syncword_dac,
  input  logic [`BT_SYNC_W-1:0] syncword_giac,
  input  logic [`BT_CORR_W-1:0] correthreshold,
  output logic                  hit_p,
  output access_mode_t          hit_mode
);

  localparam int HOLD_CW = $clog2(`BT_SYNC_W);
  localparam logic [HOLD_CW-1:0] HOLD_LAST = HOLD_CW'(`BT_SYNC_W - 1);

  logic [`BT_SYNC_W-1:0] exp_code;
  logic [`BT_CORR_W-1:0] s1_count;
  access_mode_t          s1_mode;
  logic                  s1_valid;
  logic                  s2_hit;
  corr_state_t           state;
  logic [HOLD_CW-1:0]    hold_cnt;

  function automatic logic [`BT_CORR_W-1:0] count_ones(input logic [`BT_SYNC_W-1:0] v);
    logic [`BT_CORR_W-1:0] n;
    n = '0;
    for (int i = 0; i < `BT_SYNC_W; i++)
      n = n + v[i];
    return n;
  endfunction

  always_comb
  begin
    case (access_mode)
      ACC_DAC:  exp_code = syncword_dac;
      ACC_GIAC: exp_code = syncword_giac;
      default:  exp_code = syncword_cac;
    endcase
  end

  ////////////////////////////////
  // stage 1, agreeing bit count
  ////////////////////////////////

  always_ff @(posedge clk_6M)
  begin
    s1_count <= count_ones(~(sync_window ^ exp_code));
    s1_mode  <= access_mode;
  end

  ////////////////////////////////
  // stage 2, threshold and holdoff
  ////////////////////////////////

  assign s2_hit = s1_valid && (s1_count >= correthreshold) && (state == CORR_ARMED);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      s1_valid <= 1'b0;
      hit_p    <= 1'b0;
      state    <= CORR_ARMED;
      hold_cnt <= '0;
    end
    else
    begin
      s1_valid <= bit_strobe;
      hit_p    <= s2_hit;
      if (s2_hit)
      begin
        // hit strobe counts as the first of 64
        state    <= CORR_HOLDOFF;
        hold_cnt <= HOLD_CW'(1);
      end
      else if (state == CORR_HOLDOFF && s1_valid)
      begin
        if (hold_cnt == HOLD_LAST)
          state <= CORR_ARMED;
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_6M)
  begin
    hit_mode <= s1_mode;
  end

endmodule

//--- hw/bt_sync_reporter.sv
`timescale 1ns/100ps
`include "bt_params.svh"

module bt_sync_reporter import bt_pkg::*;
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  hit_p,
  input  access_mode_t          hit_mode,
  input  logic [`BT_CLKN_W-1:0] clkn,
  input  logic                  evt_ready,
  output logic                  evt_valid,
  output logic [`BT_CLKN_W-1:0] evt_clkn,
  output access_mode_t          evt_mode,
  output logic [`BT_DROP_W-1:0] drop_count
);

  localparam logic [`BT_DROP_W-1:0] DROP_MAX = '1;

  logic holder_free;
  logic load;
  logic drop;

  // holder counts as free in the cycle its event is taken
  assign holder_free = !evt_valid || evt_ready;
  assign load        = hit_p && holder_free;
  assign drop        = hit_p && !holder_free;

  ////////////////////////////////
  // one-entry event holder
  ////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      evt_valid <= 1'b0;
    else if (load)
      evt_valid <= 1'b1;
    else if (evt_ready)
      evt_valid <= 1'b0;
  end

  // clkn as seen at the hit
  always_ff @(posedge clk_6M)
  begin
    if (load)
    begin
      evt_clkn <= clkn;
      evt_mode <= hit_mode;
    end
  end

  ////////////////////////////////
  // lost hits under back-pressure
  ////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      drop_count <= '0;
    else if (drop && drop_count != DROP_MAX)
      // saturates at all ones
      drop_count <= drop_count + 1'b1;
  end

endmodule

//--- hw/bt_timebase.sv
`timescale 1ns/100ps
`include "bt_params.svh"

module bt_timebase
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  output logic                  us_tick,
  output logic [`BT_CLKN_W-1:0] clkn,
  output logic                  slot_p
);

  localparam int US_CW = $clog2(`BT_US_DIV);
  localparam int HS_CW = $clog2(`BT_HSLOT_DIV);
  localparam logic [US_CW-1:0] US_LAST = US_CW'(`BT_US_DIV - 1);
  localparam logic [HS_CW-1:0] HS_LAST = HS_CW'(`BT_HSLOT_DIV - 1);

  logic [US_CW-1:0] us_cnt;
  logic [HS_CW-1:0] hs_cnt;
  logic             hs_wrap;

  assign hs_wrap = (hs_cnt == HS_LAST);

  ////////////////////////////////
  // 1 us divider
  ////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      us_cnt  <= '0;
      us_tick <= 1'b0;
    end
    else
    begin
      if (us_cnt == US_LAST)
        us_cnt <= '0;
      else
        us_cnt <= us_cnt + 1'b1;
      // one cycle high every 6 cycles
      us_tick <= (us_cnt == US_LAST);
    end
  end

  ////////////////////////////////
  // half slot divider and CLKN
  ////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hs_cnt <= '0;
      clkn   <= '0;
      slot_p <= 1'b0;
    end
    else
    begin
      if (hs_wrap)
        hs_cnt <= '0;
      else
        hs_cnt <= hs_cnt + 1'b1;

      // CLKN wraps at its full width
      if (hs_wrap)
        clkn <= clkn + 1'b1;

      // odd to even step of CLKN starts a new 625 us slot
      slot_p <= hs_wrap & clkn[0];
    end
  end

endmodule

//--- tb/bt_rx_checker.sv
`timescale 1ns/100ps
`include "bt_params.svh"

module bt_rx_checker import bt_pkg::*;
(
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic [`BT_CLKN_W-1:0] clkn,
  input  logic                  slot_p,
  input  logic                  evt_valid,
  input  logic                  evt_ready,
  input  logic [`BT_CLKN_W-1:0] evt_clkn,
  input  access_mode_t          evt_mode,
  input  logic [`BT_DROP_W-1:0] drop_count,
  input  int                    row_idx,
  input  logic                  row_done,
  input  logic                  exp_hit,
  input  access_mode_t          exp_mode,
  input  logic [`BT_DROP_W-1:0] exp_drop,
  input  logic                  all_done,
  input  int                    cycle_limit,
  output logic                  timed_out,
  output int                    failed_tests
);

  int                    edges;
  int                    cycles;
  int                    clock_errs;
  int                    row_errs;
  int                    accepted;
  int                    rows_run;
  logic [`BT_DROP_W-1:0] drop_base;
  logic                  prev_valid;
  logic                  prev_accept;
  logic [`BT_CLKN_W-1:0] held_clkn;
  access_mode_t          held_mode;
  logic [`BT_CLKN_W-1:0] exp_clkn;
  logic                  exp_slot;

  initial
  begin
    edges        = 0;
    cycles       = 0;
    clock_errs   = 0;
    row_errs     = 0;
    accepted     = 0;
    rows_run     = 0;
    drop_base    = '0;
    prev_valid   = 1'b0;
    prev_accept  = 1'b0;
    timed_out    = 1'b0;
    failed_tests = 0;
  end

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] expv);
    $display("Fail %s: got %h expected %h", name, got, expv);
  endtask

  task automatic finish_row();
    int                    exp_count;
    logic [`BT_DROP_W-1:0] drops;
    exp_count = exp_hit ? 1 : 0;
    drops     = drop_count - drop_base;
    if (accepted != exp_count)
    begin
      report_value("accepted events", accepted, exp_count);
      row_errs++;
    end
    if (drops !== exp_drop)
    begin
      report_value("drop_count increment", drops, exp_drop);
      row_errs++;
    end
    if (row_errs == 0)
      $display("row %0d: pass, %0d event(s)", row_idx, accepted);
    else
    begin
      $display("row %0d: fail, %0d error(s)", row_idx, row_errs);
      failed_tests++;
    end
    rows_run++;
    accepted  = 0;
    row_errs  = 0;
    drop_base = drop_count;
  endtask

  ////////////////////////////////
  // edge count and timeout
  ////////////////////////////////

  always @(posedge clk_6M)
  begin
    cycles <= cycles + 1;
    // edges seen by the DUT out of reset
    if (rstz)
      edges <= edges + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit && !timed_out)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      timed_out <= 1'b1;
    end
  end

  ////////////////////////////////
  // checks on the falling edge
  ////////////////////////////////

  always @(negedge clk_6M)
  begin
    if (!rstz)
    begin
      if (evt_valid !== 1'b0 || slot_p !== 1'b0 || clkn !== '0 || drop_count !== '0)
      begin
        $display("error: outputs are not cleared while reset is held");
        clock_errs++;
      end
    end
    else
    begin
      // one half slot per 1875 cycles, slot pulse on each even value
      exp_clkn = `BT_CLKN_W'(edges / `BT_HSLOT_DIV);
      exp_slot = (edges != 0) && (edges % `BT_HSLOT_DIV == 0) &&
                 ((edges / `BT_HSLOT_DIV) % 2 == 0);
      if (clkn !== exp_clkn)
      begin
        report_value("clkn", clkn, exp_clkn);
        clock_errs++;
      end
      if (slot_p !== exp_slot)
      begin
        report_value("slot_p", slot_p, exp_slot);
        clock_errs++;
      end

      // held event must not move
      if (prev_valid && !prev_accept)
      begin
        if (evt_valid !== 1'b1)
        begin
          $display("error: evt_valid fell before the event was taken");
          row_errs++;
        end
        else
        begin
          if (evt_clkn !== held_clkn)
          begin
            report_value("evt_clkn", evt_clkn, held_clkn);
            row_errs++;
          end
          if (evt_mode !== held_mode)
          begin
            report_value("evt_mode", evt_mode, held_mode);
            row_errs++;
          end
        end
      end
      else if (evt_valid)
      begin
        // clkn may have stepped on the load edge
        if (evt_clkn !== clkn && evt_clkn !== clkn - 1'b1)
        begin
          report_value("evt_clkn", evt_clkn, clkn);
          row_errs++;
        end
        held_clkn = evt_clkn;
        held_mode = evt_mode;
      end

      if (evt_valid && evt_ready)
      begin
        accepted++;
        if (evt_mode !== exp_mode)
        begin
          report_value("evt_mode", evt_mode, exp_mode);
          row_errs++;
        end
      end
      prev_valid  = evt_valid;
      prev_accept = evt_valid && evt_ready;

      if (row_done)
        finish_row();
    end
  end

  always @(posedge all_done)
  begin
    if (clock_errs == 0)
      $display("native clock and reset values: pass");
    else
    begin
      $display("native clock and reset values: fail, %0d error(s)", clock_errs);
      failed_tests++;
    end
    $display("tests: %0d run, %0d passed, %0d failed",
             rows_run + 1, rows_run + 1 - failed_tests, failed_tests);
  end

endmodule

//--- tb/tb_bt_rx.sv
`timescale 1ns/100ps
`include "bt_params.svh"

module tb_bt_rx import bt_pkg::*;
();

  localparam int NUM_ROWS = 10;
  localparam int DRV_DLY  = 1;
  // clk_6M cycles per air bit
  localparam int BIT_CYC  = 6;

  localparam logic [`BT_SYNC_W-1:0] CODE_CAC  = 64'h9b1c_e27f_0d53_a6c4;
  localparam logic [`BT_SYNC_W-1:0] CODE_DAC  = 64'h2ad4_6f83_b5e1_1c97;
  localparam logic [`BT_SYNC_W-1:0] CODE_GIAC = 64'h475c_58cc_7334_5e72;

  // bit error masks with 4, 5, 8 and 9 bits set
  localparam logic [`BT_SYNC_W-1:0] MASK4 = 64'h8000_0100_0010_0001;
  localparam logic [`BT_SYNC_W-1:0] MASK5 = 64'h8000_0100_0010_0081;
  localparam logic [`BT_SYNC_W-1:0] MASK8 = 64'h0f00_0000_0000_00f0;
  localparam logic [`BT_SYNC_W-1:0] MASK9 = 64'h0f00_0000_0000_01f0;

  typedef struct packed
  {
    access_mode_t          mode;
    logic [`BT_CORR_W-1:0] thresh;
    logic [7:0]            pre_len;
    access_mode_t          code_sel;
    logic [`BT_SYNC_W-1:0] mask;
    logic [1:0]            n_codes;
    logic                  hold_ready;
    logic                  exp_hit;
    access_mode_t          exp_mode;
    logic [`BT_DROP_W-1:0] exp_drop;
  } row_t;

  logic                  clk_6M;
  logic                  rstz;
  logic                  rxbit;
  access_mode_t          access_mode;
  logic [`BT_SYNC_W-1:0] syncword_cac;
  logic [`BT_SYNC_W-1:0] syncword_dac;
  logic [`BT_SYNC_W-1:0] syncword_giac;
  logic [`BT_CORR_W-1:0] correthreshold;
  logic                  evt_ready;
  logic [`BT_CLKN_W-1:0] clkn;
  logic                  slot_p;
  logic                  evt_valid;
  logic [`BT_CLKN_W-1:0] evt_clkn;
  access_mode_t          evt_mode;
  logic [`BT_DROP_W-1:0] drop_count;

  logic                  row_done;
  logic                  all_done;
  int                    row_idx;
  logic                  exp_hit;
  access_mode_t          exp_mode;
  logic [`BT_DROP_W-1:0] exp_drop;
  int                    cycle_limit;
  logic                  timed_out;
  int                    failed_tests;

  row_t                  rows [NUM_ROWS];
  logic [31:0]           lfsr_state;

  initial clk_6M = 1'b0;

  always #50 clk_6M = ~clk_6M;

  bt_rx_top DUT
  (
    .clk_6M        (clk_6M        ),
    .rstz          (rstz          ),
    .rxbit         (rxbit         ),
    .access_mode   (access_mode   ),
    .syncword_cac  (syncword_cac  ),
    .syncword_dac  (syncword_dac  ),
    .syncword_giac (syncword_giac ),
    .correthreshold(correthreshold),
    .evt_ready     (evt_ready     ),
    .clkn          (clkn          ),
    .slot_p        (slot_p        ),
    .evt_valid     (evt_valid     ),
    .evt_clkn      (evt_clkn      ),
    .evt_mode      (evt_mode      ),
    .drop_count    (drop_count    )
  );

  bt_rx_checker u_checker
  (
    .clk_6M      (clk_6M      ),
    .rstz        (rstz        ),
    .clkn        (clkn        ),
    .slot_p      (slot_p      ),
    .evt_valid   (evt_valid   ),
    .evt_ready   (evt_ready   ),
    .evt_clkn    (evt_clkn    ),
    .evt_mode    (evt_mode    ),
    .drop_count  (drop_count  ),
    .row_idx     (row_idx     ),
    .row_done    (row_done    ),
    .exp_hit     (exp_hit     ),
    .exp_mode    (exp_mode    ),
    .exp_drop    (exp_drop    ),
    .all_done    (all_done    ),
    .cycle_limit (cycle_limit ),
    .timed_out   (timed_out   ),
    .failed_tests(failed_tests)
  );

  ////////////////////////////////
  // stimulus helpers
  ////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic row_t make_row(input access_mode_t mode, input logic [6:0] thresh,
                                    input logic [7:0] pre_len, input access_mode_t code_sel,
                                    input logic [63:0] mask, input logic [1:0] n_codes,
                                    input logic hold_ready, input logic hit,
                                    input logic [7:0] drops);
    row_t r;
    r.mode       = mode;
    r.thresh     = thresh;
    r.pre_len    = pre_len;
    r.code_sel   = code_sel;
    r.mask       = mask;
    r.n_codes    = n_codes;
    r.hold_ready = hold_ready;
    r.exp_hit    = hit;
    r.exp_mode   = mode;
    r.exp_drop   = drops;
    return r;
  endfunction

  function automatic logic [`BT_SYNC_W-1:0] code_word(input access_mode_t sel);
    case (sel)
      ACC_DAC:  return CODE_DAC;
      ACC_GIAC: return CODE_GIAC;
      default:  return CODE_CAC;
    endcase
  endfunction

  // called and left just after a rising edge
  task automatic send_bit(input logic b);
    rxbit = b;
    repeat (BIT_CYC) @(posedge clk_6M);
    #DRV_DLY;
  endtask

  task automatic send_random(input int n);
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      send_bit(lfsr_state[0]);
    end
  endtask

  // first bit sent ends up at the window msb
  task automatic send_word(input logic [`BT_SYNC_W-1:0] w);
    for (int i = `BT_SYNC_W - 1; i >= 0; i--)
      send_bit(w[i]);
  endtask

  task automatic play_row(input int r);
    row_t cur;
    cur            = rows[r];
    row_idx        = r;
    access_mode    = cur.mode;
    correthreshold = cur.thresh;
    evt_ready      = !cur.hold_ready;
    exp_hit        = cur.exp_hit;
    exp_mode       = cur.exp_mode;
    exp_drop       = cur.exp_drop;
    send_random(cur.pre_len);
    for (int rep = 0; rep < cur.n_codes; rep++)
    begin
      send_word(code_word(cur.code_sel) ^ cur.mask);
      // let the hit of this code reach the holder first
      send_random(8);
      if (rep == cur.n_codes - 1)
        evt_ready = 1'b1;
      send_random(56);
    end
    if (cur.n_codes == 0)
      send_random(64);
    row_done = 1'b1;
    @(posedge clk_6M);
    #DRV_DLY;
    row_done = 1'b0;
  endtask

  ////////////////////////////////
  // main sequence
  ////////////////////////////////

  initial
  begin
    rstz           = 1'b0;
    rxbit          = 1'b0;
    access_mode    = ACC_CAC;
    syncword_cac   = CODE_CAC;
    syncword_dac   = CODE_DAC;
    syncword_giac  = CODE_GIAC;
    correthreshold = 7'd64;
    evt_ready      = 1'b0;
    row_done       = 1'b0;
    all_done       = 1'b0;
    row_idx        = 0;
    exp_hit        = 1'b0;
    exp_mode       = ACC_CAC;
    exp_drop       = '0;
    lfsr_state     = 32'hee67;

    // exact match per mode, threshold edges, wrong code, noise, back-pressure
    rows[0] = make_row(ACC_CAC,  7'd64, 8'd20,  ACC_CAC,  '0,    2'd1, 1'b0, 1'b1, 8'd0);
    rows[1] = make_row(ACC_DAC,  7'd64, 8'd13,  ACC_DAC,  '0,    2'd1, 1'b0, 1'b1, 8'd0);
    rows[2] = make_row(ACC_GIAC, 7'd64, 8'd27,  ACC_GIAC, '0,    2'd1, 1'b0, 1'b1, 8'd0);
    rows[3] = make_row(ACC_CAC,  7'd60, 8'd9,   ACC_CAC,  MASK4, 2'd1, 1'b0, 1'b1, 8'd0);
    rows[4] = make_row(ACC_CAC,  7'd60, 8'd16,  ACC_CAC,  MASK5, 2'd1, 1'b0, 1'b0, 8'd0);
    rows[5] = make_row(ACC_DAC,  7'd56, 8'd11,  ACC_DAC,  MASK8, 2'd1, 1'b0, 1'b1, 8'd0);
    rows[6] = make_row(ACC_DAC,  7'd56, 8'd22,  ACC_DAC,  MASK9, 2'd1, 1'b0, 1'b0, 8'd0);
    rows[7] = make_row(ACC_CAC,  7'd60, 8'd14,  ACC_DAC,  '0,    2'd1, 1'b0, 1'b0, 8'd0);
    rows[8] = make_row(ACC_GIAC, 7'd60, 8'd100, ACC_GIAC, '0,    2'd0, 1'b0, 1'b0, 8'd0);
    rows[9] = make_row(ACC_GIAC, 7'd64, 8'd18,  ACC_GIAC, '0,    2'd2, 1'b1, 1'b1, 8'd1);

    // reset plus margin, then every row at 6 cycles per bit
    cycle_limit = 5 + 2000;
    for (int r = 0; r < NUM_ROWS; r++)
      cycle_limit = cycle_limit + (rows[r].pre_len + 128 *
                    ((rows[r].n_codes == 0) ? 1 : rows[r].n_codes)) * BIT_CYC;

    repeat (5) @(posedge clk_6M);
    #DRV_DLY;
    rstz = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++)
      play_row(r);

    all_done = 1'b1;
    @(negedge clk_6M);
    #1;
    if (failed_tests == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  always @(posedge timed_out)
  begin
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
